//--- design/icache_controller.sv
/*
 * Miss handling controller of the instruction cache
 * Request capture stage and lookup state machine
 * Four-phase req/ack toward fetch and toward memory
 * Refill into the LRU way, kill and drain of a pending read
 */
`timescale 1ns/100ps
`default_nettype none

module icache_controller (
  input  wire                      clk_i,
  input  wire                      rst_ni,

  // Fetch side
  input  wire                      if_req_i,
  input  wire                      if_kill_i,
  input  wire icache_pkg::addr_t   if_addr_i,
  output logic                     if_ack_o,
  output icache_pkg::instr_t       if_instr_o,

  // Memory side
  input  wire                      mem_ack_i,
  input  wire icache_pkg::line_t   mem_line_i,
  output logic                     mem_req_o,
  output icache_pkg::addr_t        mem_addr_o,

  icache_lookup_if.ctrl            lk
);
  import icache_pkg::*;

  icache_state_e state_q;

  // Captured request fields
  tag_t          req_tag_q;
  index_t        req_index_q;
  offset_t       req_offset_q;

  // Address is taken whenever a request is seen in IDLE
  always_ff @(posedge clk_i) begin
    if (state_q == ICACHE_IDLE && if_req_i) begin
      req_tag_q    <= if_addr_i[ICACHE_TAG_LSB +: $bits(tag_t)];
      req_index_q  <= if_addr_i[ICACHE_INDEX_LSB +: $bits(index_t)];
      req_offset_q <= if_addr_i[ICACHE_OFFSET_LSB +: $bits(offset_t)];
    end
  end

  assign lk.tag    = req_tag_q;
  assign lk.index  = req_index_q;
  assign lk.offset = req_offset_q;

  // Line-aligned read address, held while the request is captured
  assign mem_addr_o = {req_tag_q, req_index_q, {ICACHE_INDEX_LSB{1'b0}}};

  // Line is written at the edge where the memory ack is seen
  // a kill in that same cycle discards it
  assign lk.fill_en   = (state_q == ICACHE_READ_MEMORY) && mem_ack_i && !if_kill_i;
  assign lk.fill_way  = lk.victim_way;
  assign lk.fill_line = mem_line_i;

  // Returned word
  // in MEM_RELEASE the data array reads back the filled line
  always_ff @(posedge clk_i) begin
    if ((state_q == ICACHE_LOOKUP && lk.hit) || state_q == ICACHE_MEM_RELEASE) begin
      if_instr_o <= lk.rd_instr;
    end
  end

  // Main state machine with both handshakes
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q   <= ICACHE_IDLE;
      if_ack_o  <= 1'b0;
      mem_req_o <= 1'b0;
    end else begin
      unique case (state_q)
        ICACHE_IDLE: begin
          if (if_req_i && !if_kill_i) begin
            state_q <= ICACHE_LOOKUP;
          end
        end
        ICACHE_LOOKUP: begin
          if (if_kill_i) begin
            // Dropped before any memory traffic
            state_q <= ICACHE_IDLE;
          end else if (lk.hit) begin
            if_ack_o <= 1'b1;
            state_q  <= ICACHE_RESPOND;
          end else begin
            mem_req_o <= 1'b1;
            state_q   <= ICACHE_READ_MEMORY;
          end
        end
        ICACHE_READ_MEMORY: begin
          if (if_kill_i) begin
            state_q <= ICACHE_DRAIN;
          end else if (mem_ack_i) begin
            state_q <= ICACHE_MEM_RELEASE;
          end
        end
        ICACHE_MEM_RELEASE: begin
          // Line stays filled even if fetch goes away now
          if (if_kill_i) begin
            state_q <= ICACHE_DRAIN;
          end else if (mem_req_o) begin
            mem_req_o <= 1'b0;
          end else if (!mem_ack_i) begin
            state_q <= ICACHE_RESPOND;
          end
        end
        ICACHE_RESPOND: begin
          if (!if_ack_o) begin
            // Miss path, ack only if the request is still alive
            if (if_kill_i || !if_req_i) begin
              state_q <= ICACHE_IDLE;
            end else begin
              if_ack_o <= 1'b1;
            end
          end else if (!if_req_i) begin
            if_ack_o <= 1'b0;
            state_q  <= ICACHE_IDLE;
          end
        end
        ICACHE_DRAIN: begin
          // Finish the memory handshake, nothing is kept
          if (mem_req_o) begin
            if (mem_ack_i) begin
              mem_req_o <= 1'b0;
            end
          end else if (!mem_ack_i) begin
            state_q <= ICACHE_IDLE;
          end
        end
        default: begin
          state_q <= ICACHE_IDLE;
        end
      endcase
    end
  end

  // Fetch ack only answers a request that was up when it was raised
  a_ack_needs_req: assert property (
    @(posedge clk_i) disable iff (!rst_ni) $rose(if_ack_o) |-> $past(if_req_i)
  ) else $error("controller: if_ack_o rose without if_req_i");

  // Memory request is held until memory has delivered the line
  a_mem_req_held: assert property (
    @(posedge clk_i) disable iff (!rst_ni) $fell(mem_req_o) |-> $past(mem_ack_i)
  ) else $error("controller: mem_req_o fell before mem_ack_i");

endmodule

`default_nettype wire

//--- design/icache_data_array.sv
/*
 * Data array of the instruction cache
 * One line per set and way, written whole on a fill
 * Word select from the hit way or the way just filled
 */
`timescale 1ns/100ps
`default_nettype none

module icache_data_array #(
  parameter int NO_OF_SETS = icache_pkg::ICACHE_NO_OF_SETS,
  parameter int NO_OF_WAYS = icache_pkg::ICACHE_NO_OF_WAYS,
  parameter int LINE_WORDS = icache_pkg::ICACHE_LINE_WORDS
) (
  input wire              clk_i,
  icache_lookup_if.data   lk
);
  import icache_pkg::*;

  // Line storage split into words
  instr_t words_q [NO_OF_SETS][NO_OF_WAYS][LINE_WORDS];

  // Remembers the way of a fill in the previous cycle
  logic   fill_q;
  way_t   fill_way_q;
  way_t   rd_way;

  // Whole line written in one cycle
  always_ff @(posedge clk_i) begin
    if (lk.fill_en) begin
      for (int w = 0; w < LINE_WORDS; w++) begin
        words_q[lk.index][lk.fill_way][w] <= lk.fill_line[w*$bits(instr_t) +: $bits(instr_t)];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    fill_q     <= lk.fill_en;
    fill_way_q <= lk.fill_way;
  end

  // Right after a fill read the filled way
  // otherwise the way reported by the tag compare
  assign rd_way = fill_q ? fill_way_q : lk.hit_way;

  assign lk.rd_instr = words_q[lk.index][rd_way][lk.offset];

endmodule

`default_nettype wire

//--- design/icache_lookup_if.sv
/*
 * Lookup interface between the cache controller and the arrays
 * Captured request fields, fill controls, hit and victim results
 * Modports for controller, tag array and data array
 */
`timescale 1ns/100ps
`default_nettype none

interface icache_lookup_if;
  import icache_pkg::*;

  // Captured request
  index_t  index;
  tag_t    tag;
  offset_t offset;

  // Line fill from memory
  logic    fill_en;
  way_t    fill_way;
  line_t   fill_line;

  // Tag compare results
  logic    hit;
  way_t    hit_way;
  way_t    victim_way;

  // Selected word
  instr_t  rd_instr;

  modport ctrl (output index, tag, offset, fill_en, fill_way, fill_line,
                input  hit, hit_way, victim_way, rd_instr);

  modport tags (input  index, tag, fill_en, fill_way,
                output hit, hit_way, victim_way);

  modport data (input  index, offset, hit_way, fill_en, fill_way, fill_line,
                output rd_instr);

endinterface

`default_nettype wire

//--- design/icache_pkg.sv
/*
 * Instruction cache shared definitions
 * Geometry constants and address field positions
 * Address, instruction, field and line types
 * Controller state encoding
 */
`default_nettype none

package icache_pkg;

  // Cache geometry, 2-way with 8 sets of 16-byte lines
  localparam int ICACHE_NO_OF_SETS  = 8;
  localparam int ICACHE_NO_OF_WAYS  = 2;
  localparam int ICACHE_LINE_WORDS  = 4;

  // Bit positions of the address fields
  localparam int ICACHE_OFFSET_LSB  = 2;
  localparam int ICACHE_INDEX_LSB   = 4;
  localparam int ICACHE_TAG_LSB     = 7;

  // Byte address and instruction word
  typedef logic [31:0] addr_t;
  typedef logic [31:0] instr_t;

  // Address fields
  // index is bits 6..4, offset is bits 3..2, tag is bits 31..7
  typedef logic [2:0]  index_t;
  typedef logic [1:0]  offset_t;
  typedef logic [24:0] tag_t;

  // Way number, one bit for two ways
  typedef logic        way_t;

  // Whole line, word 0 in the low bits
  typedef logic [127:0] line_t;

  // Miss handling controller states
  typedef enum logic [2:0] {
    ICACHE_IDLE,
    ICACHE_LOOKUP,
    ICACHE_READ_MEMORY,
    ICACHE_MEM_RELEASE,
    ICACHE_RESPOND,
    ICACHE_DRAIN
  } icache_state_e;

endpackage

`default_nettype wire

//--- design/icache_tag_array.sv
/*
 * Tag array of the instruction cache
 * Tag and valid storage per set and way
 * Parallel compare of all ways, one LRU bit per set
 * Victim way choice for line fills
 */
`timescale 1ns/100ps
`default_nettype none

module icache_tag_array #(
  parameter int NO_OF_SETS = icache_pkg::ICACHE_NO_OF_SETS,
  parameter int NO_OF_WAYS = icache_pkg::ICACHE_NO_OF_WAYS
) (
  input wire              clk_i,
  input wire              rst_ni,
  icache_lookup_if.tags   lk
);
  import icache_pkg::*;

  // Tags carry no reset, valid bits guard them
  tag_t                  tag_q   [NO_OF_SETS][NO_OF_WAYS];
  logic [NO_OF_WAYS-1:0] valid_q [NO_OF_SETS];

  // Each LRU bit names the way to replace next
  logic [NO_OF_SETS-1:0] lru_q;

  logic [NO_OF_WAYS-1:0] way_hit;

  // Compare every way of the indexed set at once
  always_comb begin
    for (int w = 0; w < NO_OF_WAYS; w++) begin
      way_hit[w] = valid_q[lk.index][w] && (tag_q[lk.index][w] == lk.tag);
    end
  end

  // Encode the hitting way
  always_comb begin
    lk.hit_way = '0;
    for (int w = 0; w < NO_OF_WAYS; w++) begin
      if (way_hit[w]) begin
        lk.hit_way = way_t'(w);
      end
    end
  end

  assign lk.hit        = |way_hit;
  assign lk.victim_way = lru_q[lk.index];

  // New tag goes into the victim way on a fill
  always_ff @(posedge clk_i) begin
    if (lk.fill_en) begin
      tag_q[lk.index][lk.fill_way] <= lk.tag;
    end
  end

  // Valid and LRU state
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int s = 0; s < NO_OF_SETS; s++) begin
        valid_q[s] <= '0;
      end
      lru_q <= '0;
    end else begin
      if (lk.fill_en) begin
        valid_q[lk.index][lk.fill_way] <= 1'b1;
        // Freshly filled way is the most recent one
        lru_q[lk.index] <= ~lk.fill_way;
      end else if (lk.hit) begin
        // Point away from the way just used
        lru_q[lk.index] <= ~lk.hit_way;
      end
    end
  end

  // Fills only go to sets that missed, so one tag lives in one way at most
  a_single_way_hit: assert property (
    @(posedge clk_i) disable iff (!rst_ni) $onehot0(way_hit)
  ) else $error("tag array: more than one way hit");

endmodule

`default_nettype wire

//--- design/icache_top.sv
/*
 * Instruction cache top level
 * Fetch and memory ports, lookup interface
 * Controller, tag array and data array
 */
`timescale 1ns/100ps
`default_nettype none

module icache_top #(
  parameter int NO_OF_SETS = icache_pkg::ICACHE_NO_OF_SETS,
  parameter int NO_OF_WAYS = icache_pkg::ICACHE_NO_OF_WAYS,
  parameter int LINE_WORDS = icache_pkg::ICACHE_LINE_WORDS
) (
  input  wire                      clk_i,
  input  wire                      rst_ni,

  // Fetch stage
  input  wire                      if_req_i,
  input  wire                      if_kill_i,
  input  wire icache_pkg::addr_t   if_addr_i,
  output logic                     if_ack_o,
  output icache_pkg::instr_t       if_instr_o,

  // Instruction memory
  input  wire                      mem_ack_i,
  input  wire icache_pkg::line_t   mem_line_i,
  output logic                     mem_req_o,
  output icache_pkg::addr_t        mem_addr_o
);

  icache_lookup_if lk ();

  icache_controller u_ctrl (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .if_req_i   (if_req_i),
    .if_kill_i  (if_kill_i),
    .if_addr_i  (if_addr_i),
    .if_ack_o   (if_ack_o),
    .if_instr_o (if_instr_o),
    .mem_ack_i  (mem_ack_i),
    .mem_line_i (mem_line_i),
    .mem_req_o  (mem_req_o),
    .mem_addr_o (mem_addr_o),
    .lk         (lk.ctrl)
  );

  // Tags, valid bits and LRU
  icache_tag_array #(
    .NO_OF_SETS (NO_OF_SETS),
    .NO_OF_WAYS (NO_OF_WAYS)
  ) u_tags (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .lk     (lk.tags)
  );

  // Line storage
  icache_data_array #(
    .NO_OF_SETS (NO_OF_SETS),
    .NO_OF_WAYS (NO_OF_WAYS),
    .LINE_WORDS (LINE_WORDS)
  ) u_data (
    .clk_i (clk_i),
    .lk    (lk.data)
  );

endmodule

`default_nettype wire

//--- src.f
design/icache_pkg.sv
design/icache_lookup_if.sv
design/icache_tag_array.sv
design/icache_data_array.sv
design/icache_controller.sv
design/icache_top.sv
verif/icache_checker.sv
verif/icache_tb.sv

//--- verif/icache_checker.sv
/*
 * Reference model and checker for the instruction cache
 * Tag, valid and LRU model that predicts hit or miss of every fetch
 * Instruction value, memory address and handshake order checks
 */
`timescale 1ns/100ps
`default_nettype none

module icache_checker (
  input  wire                     clk_i,
  input  wire                     rst_ni,
  input  wire                     if_req_i,
  input  wire                     if_kill_i,
  input  wire icache_pkg::addr_t  if_addr_i,
  input  wire                     if_ack_i,
  input  wire icache_pkg::instr_t if_instr_i,
  input  wire                     mem_ack_i,
  input  wire                     mem_req_i,
  input  wire icache_pkg::addr_t  mem_addr_i,
  output int                      value_errs_o,
  output int                      proto_errs_o
);
  import icache_pkg::*;

  localparam int SETS = ICACHE_NO_OF_SETS;
  localparam int WAYS = ICACHE_NO_OF_WAYS;

  // Model of tags, valid bits and LRU bits
  tag_t  m_tag   [SETS][WAYS];
  logic  m_valid [SETS][WAYS];
  way_t  m_lru   [SETS];

  // Outstanding fetch and its line read
  logic  busy;
  logic  pend_hit;
  logic  pend_killed;
  logic  rd_open;
  logic  after_reset;
  addr_t pend_addr;
  int    pend_age;
  int    pend_reads;

  // Port values at the previous edge
  logic  req_q;
  logic  ack_q;
  logic  mreq_q;
  logic  mack_q;

  int    value_errs = 0;
  int    proto_errs = 0;

  assign value_errs_o = value_errs;
  assign proto_errs_o = proto_errs;

  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("FAILED at %0t: %s = %h, expected %h", $time, sig, got, exp);
    value_errs++;
  endtask

  task automatic report_protocol(input string what);
    $display("Protocol error at %0t: %s", $time, what);
    proto_errs++;
  endtask

  always @(posedge clk_i) begin : check_edge
    index_t s;
    tag_t   t;
    way_t   w;
    if (!rst_ni) begin
      for (int i = 0; i < SETS; i++) begin
        m_lru[i] = 1'b0;
        for (int j = 0; j < WAYS; j++) begin
          m_valid[i][j] = 1'b0;
        end
      end
      busy        = 1'b0;
      pend_killed = 1'b0;
      rd_open     = 1'b0;
      after_reset = 1'b1;
      req_q       = 1'b0;
      ack_q       = 1'b0;
      mreq_q      = 1'b0;
      mack_q      = 1'b0;
    end else begin
      if (after_reset && (if_ack_i || mem_req_i)) begin
        report_protocol("if_ack_o or mem_req_o high on the first edge after reset");
      end
      after_reset = 1'b0;

      // Hit or miss of a new fetch comes from the model
      // A hit makes the LRU bit point at the other way
      if (if_req_i && !req_q) begin
        s           = if_addr_i[6:4];
        t           = if_addr_i[31:7];
        busy        = 1'b1;
        pend_addr   = if_addr_i;
        pend_age    = 0;
        pend_reads  = 0;
        pend_killed = 1'b0;
        pend_hit    = 1'b0;
        for (int j = 0; j < WAYS; j++) begin
          if (m_valid[s][j] && m_tag[s][j] == t) begin
            pend_hit = 1'b1;
            m_lru[s] = ~way_t'(j);
          end
        end
      end else begin
        pend_age++;
      end

      // Hit acks and miss reads both show up two edges after the request
      if (busy && !pend_killed && pend_age == 2) begin
        if (pend_hit && !if_ack_i) begin
          report_mismatch("if_ack_o", 32'(if_ack_i), 32'd1);
        end
        if (!pend_hit && !mem_req_i) begin
          report_mismatch("mem_req_o", 32'(mem_req_i), 32'd1);
        end
      end

      // Start of a line read
      // the cache decided one edge earlier, when mem_ack_i had to be low
      if (mem_req_i && !mreq_q) begin
        if (!busy || pend_hit || pend_killed) begin
          report_protocol("memory read without a pending miss");
        end
        if (pend_reads > 0) begin
          report_protocol("second memory read for one fetch");
        end
        if (mem_addr_i != {pend_addr[31:4], 4'b0000}) begin
          report_mismatch("mem_addr_o", mem_addr_i, {pend_addr[31:4], 4'b0000});
        end
        if (mack_q) begin
          report_protocol("mem_req_o raised while mem_ack_i was still high");
        end
        pend_reads++;
        rd_open = 1'b1;
      end

      if (if_kill_i) begin
        pend_killed = 1'b1;
      end

      // Line lands at the ack edge unless the fetch was killed by then
      if (rd_open && mem_ack_i) begin
        rd_open = 1'b0;
        if (!pend_killed) begin
          s              = pend_addr[6:4];
          w              = m_lru[s];
          m_tag[s][w]    = pend_addr[31:7];
          m_valid[s][w]  = 1'b1;
          m_lru[s]       = ~w;
        end
      end

      if (!mem_req_i && mreq_q && rd_open) begin
        report_protocol("mem_req_o fell before mem_ack_i arrived");
      end

      // Fetch ack order and returned word
      if (if_ack_i && !ack_q) begin
        if (!busy || pend_killed) begin
          report_protocol("if_ack_o for a fetch that was killed or never made");
        end else if (!req_q) begin
          report_protocol("if_ack_o rose while if_req_i was low");
        end else if (!pend_hit && (pend_reads == 0 || rd_open)) begin
          report_protocol("miss acknowledged before its line was read");
        end else if (pend_hit && pend_age != 2) begin
          report_protocol("hit acknowledged other than two cycles after the request");
        end
        if (if_instr_i != ({pend_addr[31:2], 2'b00} ^ 32'hC0DE_0000)) begin
          report_mismatch("if_instr_o", if_instr_i,
                          {pend_addr[31:2], 2'b00} ^ 32'hC0DE_0000);
        end
      end
      if (if_ack_i && ack_q && !req_q) begin
        report_protocol("if_ack_o still high a cycle after if_req_i fell");
      end
      if (!if_ack_i && ack_q) begin
        if (req_q) begin
          report_protocol("if_ack_o fell while if_req_i was high");
        end
        busy = 1'b0;
      end

      req_q  = if_req_i;
      ack_q  = if_ack_i;
      mreq_q = mem_req_i;
      mack_q = mem_ack_i;
    end
  end

endmodule

`default_nettype wire

//--- verif/icache_tb.sv
/*
 * Instruction cache testbench
 * Clock, reset, directed table and LCG random fetches
 * Line memory model, watchdog and final report
 */
`timescale 1ns/100ps
`default_nettype none

module icache_tb;
  import icache_pkg::*;

  localparam int          CLK_HALF     = 5;
  localparam int          RESET_CYCLES = 8;
  localparam int          TABLE_LEN    = 17;
  localparam int          NO_OF_RANDOM = 40;
  localparam int          WAIT_LIMIT   = 40;
  localparam logic [31:0] SEED         = 32'h8388;

  // kill_dly 0 means no kill
  // exp_reads is the number of line reads the fetch must cause
  typedef struct packed {
    logic [31:0] addr;
    logic [3:0]  kill_dly;
    logic [3:0]  mem_dly;
    logic [1:0]  exp_reads;
  } entry_t;

  localparam entry_t STIM [TABLE_LEN] = '{
    // Cold miss in set 2, then repeat and same-line hits
    '{32'h0000_1020, 4'd0, 4'd3, 2'd1},
    '{32'h0000_1020, 4'd0, 4'd3, 2'd0},
    '{32'h0000_102C, 4'd0, 4'd3, 2'd0},
    // Second tag takes the other way, both stay resident
    '{32'h0000_2024, 4'd0, 4'd2, 2'd1},
    '{32'h0000_2020, 4'd0, 4'd2, 2'd0},
    '{32'h0000_1028, 4'd0, 4'd2, 2'd0},
    // Third tag evicts the second, first still hits
    '{32'h0000_3020, 4'd0, 4'd4, 2'd1},
    '{32'h0000_1024, 4'd0, 4'd4, 2'd0},
    '{32'h0000_2028, 4'd0, 4'd1, 2'd1},
    '{32'h0000_1020, 4'd0, 4'd1, 2'd0},
    // Kill in lookup, kill during refill, line then misses
    '{32'h0000_0440, 4'd1, 4'd6, 2'd0},
    '{32'h0000_0440, 4'd3, 4'd6, 2'd1},
    '{32'h0000_0444, 4'd0, 4'd2, 2'd1},
    '{32'h0000_0448, 4'd0, 4'd2, 2'd0},
    // Fast and slow memory
    '{32'h0000_5060, 4'd0, 4'd0, 2'd1},
    '{32'h0000_6064, 4'd0, 4'd9, 2'd1},
    '{32'h0000_5068, 4'd0, 4'd1, 2'd0}
  };

  logic    clk_i;
  logic    rst_ni;
  logic    if_req_i;
  logic    if_kill_i;
  addr_t   if_addr_i;
  logic    if_ack_o;
  instr_t  if_instr_o;
  logic    mem_ack_i;
  line_t   mem_line_i;
  logic    mem_req_o;
  addr_t   mem_addr_o;

  int      mem_dly;
  int      mem_reads = 0;
  int      tb_errors = 0;
  int      value_errs;
  int      proto_errs;

  icache_top dut0 (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .if_req_i   (if_req_i),
    .if_kill_i  (if_kill_i),
    .if_addr_i  (if_addr_i),
    .if_ack_o   (if_ack_o),
    .if_instr_o (if_instr_o),
    .mem_ack_i  (mem_ack_i),
    .mem_line_i (mem_line_i),
    .mem_req_o  (mem_req_o),
    .mem_addr_o (mem_addr_o)
  );

  icache_checker u_checker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .if_req_i     (if_req_i),
    .if_kill_i    (if_kill_i),
    .if_addr_i    (if_addr_i),
    .if_ack_i     (if_ack_o),
    .if_instr_i   (if_instr_o),
    .mem_ack_i    (mem_ack_i),
    .mem_req_i    (mem_req_o),
    .mem_addr_i   (mem_addr_o),
    .value_errs_o (value_errs),
    .proto_errs_o (proto_errs)
  );

  initial begin
    clk_i = 1'b0;
    forever #CLK_HALF clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_random(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Word k of the line at A is (A + 4k) ^ 32'hC0DE0000
  function automatic line_t memory_line(input addr_t a);
    line_t l;
    for (int k = 0; k < ICACHE_LINE_WORDS; k++) begin
      l[k*32 +: 32] = ({a[31:4], 4'b0000} + 32'(4 * k)) ^ 32'hC0DE_0000;
    end
    return l;
  endfunction

  // Instruction memory, answers each line read after mem_dly cycles
  initial begin : memory_model
    mem_ack_i  = 1'b0;
    mem_line_i = '0;
    forever begin
      @(negedge clk_i);
      if (mem_req_o && !mem_ack_i) begin
        repeat (mem_dly) @(negedge clk_i);
        mem_line_i = memory_line(mem_addr_o);
        mem_ack_i  = 1'b1;
        mem_reads++;
        // Hold the line until the cache drops its request
        do begin
          @(negedge clk_i);
        end while (mem_req_o);
        mem_ack_i = 1'b0;
      end
    end
  end

  task automatic fetch_one(input addr_t addr, input int kill_dly, input int dly,
                           input int exp_reads);
    int reads_before;
    int waited;
    mem_dly      = dly;
    reads_before = mem_reads;
    @(negedge clk_i);
    if_addr_i = addr;
    if_req_i  = 1'b1;
    if (kill_dly > 0) begin
      repeat (kill_dly) @(negedge clk_i);
      // Request withdrawn in the kill cycle
      if_kill_i = 1'b1;
      if_req_i  = 1'b0;
      @(negedge clk_i);
      if_kill_i = 1'b0;
    end else begin
      waited = 0;
      while (!if_ack_o && waited < WAIT_LIMIT) begin
        @(negedge clk_i);
        waited++;
      end
      if (!if_ack_o) begin
        $display("Time %0t: no if_ack_o for the fetch of %h", $time, addr);
        tb_errors++;
      end
      if_req_i = 1'b0;
      waited   = 0;
      while (if_ack_o && waited < WAIT_LIMIT) begin
        @(negedge clk_i);
        waited++;
      end
      if (if_ack_o) begin
        $display("Time %0t: if_ack_o stuck high after the fetch of %h", $time, addr);
        tb_errors++;
      end
    end
    // Refill or drain finishes before the next fetch
    waited = 0;
    while ((mem_req_o || mem_ack_i) && waited < WAIT_LIMIT) begin
      @(negedge clk_i);
      waited++;
    end
    if (mem_req_o) begin
      $display("Time %0t: memory handshake did not finish for %h", $time, addr);
      tb_errors++;
    end
    repeat (2) @(negedge clk_i);
    if (exp_reads >= 0 && mem_reads - reads_before != exp_reads) begin
      $display("FAILED at %0t: mem_req_o reads for %h = %0d, expected %0d",
               $time, addr, mem_reads - reads_before, exp_reads);
      tb_errors++;
    end
  endtask

  initial begin : stimulus
    logic [31:0] seed;
    addr_t       raddr;
    int          total;
    rst_ni    = 1'b0;
    if_req_i  = 1'b0;
    if_kill_i = 1'b0;
    if_addr_i = '0;
    mem_dly   = 0;
    seed      = SEED;
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;
    repeat (2) @(negedge clk_i);

    for (int i = 0; i < TABLE_LEN; i++) begin
      fetch_one(STIM[i].addr, int'(STIM[i].kill_dly), int'(STIM[i].mem_dly),
                int'(STIM[i].exp_reads));
    end

    // 4 tags x 8 sets x 4 words, memory delay 0 to 3
    for (int i = 0; i < NO_OF_RANDOM; i++) begin
      seed  = next_random(seed);
      raddr = 32'h0001_0000 | {23'd0, seed[22:16], 2'b00};
      fetch_one(raddr, 0, int'(seed[25:24]), -1);
    end

    total = value_errs + proto_errs + tb_errors;
    $display("Error counts: value %0d, protocol %0d, testbench %0d",
             value_errs, proto_errs, tb_errors);
    if (total == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (RESET_CYCLES + (TABLE_LEN + NO_OF_RANDOM) * 60) @(posedge clk_i);
    $display("Watchdog expired, the fetch sequence did not finish in time");
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire
